//--- Makefile
SIM := obj_dir/Vtb_memcopy_periph

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): memcopy_periph.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_memcopy_periph -f memcopy_periph.f

clean:
	rm -rf obj_dir

//--- memcopy_bus_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Memory-copy bus arbiter, writer first, routes in-order responses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memcopy_bus_arbiter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               rd_req_i,
  input  memcopy_pkg::addr_t rd_addr_i,
  output logic               rd_gnt_o,
  output logic               rd_rvalid_o,
  input  logic               wr_req_i,
  input  memcopy_pkg::addr_t wr_addr_i,
  input  memcopy_pkg::data_t wr_wdata_i,
  output logic               wr_gnt_o,
  output logic               wr_rvalid_o,
  output logic               obi_req_o,
  output logic               obi_we_o,
  output memcopy_pkg::be_t   obi_be_o,
  output memcopy_pkg::addr_t obi_addr_o,
  output memcopy_pkg::data_t obi_wdata_o,
  input  logic               obi_gnt_i,
  input  logic               obi_rvalid_i
);

  // Owner of each outstanding transaction, 1 means writer
  logic                  owner_q [memcopy_pkg::ARB_DEPTH];
  memcopy_pkg::arb_ptr_t tail_q;
  memcopy_pkg::arb_ptr_t head_q;
  memcopy_pkg::arb_cnt_t outstanding_q;
  logic                  lock_q;
  logic                  lock_wr_q;
  logic                  sel_wr;
  logic                  can_grant;
  logic                  bus_gnt;

  assign can_grant = outstanding_q != memcopy_pkg::arb_cnt_t'(memcopy_pkg::ARB_DEPTH);

  // A pending request keeps its engine even if the writer shows up
  assign sel_wr = lock_q ? lock_wr_q : wr_req_i;

  assign obi_req_o   = can_grant && (rd_req_i || wr_req_i);
  assign obi_we_o    = sel_wr;
  assign obi_be_o    = '1;
  assign obi_addr_o  = sel_wr ? wr_addr_i : rd_addr_i;
  assign obi_wdata_o = wr_wdata_i;

  assign bus_gnt     = obi_req_o && obi_gnt_i;
  assign rd_gnt_o    = bus_gnt && !sel_wr;
  assign wr_gnt_o    = bus_gnt && sel_wr;
  assign wr_rvalid_o = obi_rvalid_i && owner_q[head_q];
  assign rd_rvalid_o = obi_rvalid_i && !owner_q[head_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tail_q        <= '0;
      head_q        <= '0;
      outstanding_q <= '0;
      lock_q        <= 1'b0;
      lock_wr_q     <= 1'b0;
    end else begin
      lock_q    <= obi_req_o && !obi_gnt_i;
      lock_wr_q <= sel_wr;
      if (bus_gnt) begin
        tail_q <= tail_q + 1'b1;
      end
      if (obi_rvalid_i) begin
        head_q <= head_q + 1'b1;
      end
      case ({bus_gnt, obi_rvalid_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_gnt) begin
      owner_q[tail_q] <= sel_wr;
    end
  end

endmodule

`default_nettype wire

//--- memcopy_fifo.sv
//////////////////////////////////////////////////////////////////////
// Memory-copy data buffer, head word visible, reports free entries
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memcopy_fifo (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   push_i,
  input  memcopy_pkg::data_t     wdata_i,
  input  logic                   pop_i,
  output memcopy_pkg::data_t     rdata_o,
  output logic                   empty_o,
  output memcopy_pkg::fifo_cnt_t free_o
);

  memcopy_pkg::data_t     mem_q [memcopy_pkg::FIFO_DEPTH];
  memcopy_pkg::fifo_ptr_t wr_ptr_q;
  memcopy_pkg::fifo_ptr_t rd_ptr_q;
  memcopy_pkg::fifo_cnt_t count_q;

  assign rdata_o = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign free_o  = memcopy_pkg::fifo_cnt_t'(memcopy_pkg::FIFO_DEPTH) - count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- memcopy_periph.f
memcopy_pkg.sv
memcopy_regs.sv
memcopy_reader.sv
memcopy_fifo.sv
memcopy_writer.sv
memcopy_bus_arbiter.sv
memcopy_periph.sv
slow_memory_model.sv
memcopy_periph_assertions.sv
tb_memcopy_periph.sv

//--- memcopy_periph.sv
//////////////////////////////////////////////////////////////////////
// Memory-copy peripheral top: register port in, one bus master out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memcopy_periph (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  memcopy_pkg::reg_addr_t reg_addr_i,
  input  memcopy_pkg::data_t     reg_wdata_i,
  output logic                   reg_ready_o,
  output memcopy_pkg::data_t     reg_rdata_o,
  output logic                   reg_error_o,
  output logic                   obi_req_o,
  output logic                   obi_we_o,
  output memcopy_pkg::be_t       obi_be_o,
  output memcopy_pkg::addr_t     obi_addr_o,
  output memcopy_pkg::data_t     obi_wdata_o,
  input  logic                   obi_gnt_i,
  input  memcopy_pkg::data_t     obi_rdata_i,
  input  logic                   obi_rvalid_i,
  output logic                   memcopy_intr_o
);

  logic                   start;
  logic                   done;
  memcopy_pkg::addr_t     src_ptr;
  memcopy_pkg::addr_t     dst_ptr;
  memcopy_pkg::word_cnt_t size;
  logic                   rd_req;
  logic                   rd_gnt;
  logic                   rd_rvalid;
  memcopy_pkg::addr_t     rd_addr;
  logic                   wr_req;
  logic                   wr_gnt;
  logic                   wr_rvalid;
  memcopy_pkg::addr_t     wr_addr;
  memcopy_pkg::data_t     wr_wdata;
  logic                   fifo_pop;
  logic                   fifo_empty;
  memcopy_pkg::data_t     fifo_rdata;
  memcopy_pkg::fifo_cnt_t fifo_free;

  memcopy_regs i_memcopy_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_ready_o (reg_ready_o),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .start_o     (start),
    .src_ptr_o   (src_ptr),
    .dst_ptr_o   (dst_ptr),
    .size_o      (size),
    .done_i      (done),
    .intr_o      (memcopy_intr_o)
  );

  memcopy_reader i_memcopy_reader (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .start_i     (start),
    .src_ptr_i   (src_ptr),
    .size_i      (size),
    .req_o       (rd_req),
    .addr_o      (rd_addr),
    .gnt_i       (rd_gnt),
    .rvalid_i    (rd_rvalid),
    .fifo_free_i (fifo_free)
  );

  // Read responses land in the buffer directly
  memcopy_fifo i_memcopy_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (rd_rvalid),
    .wdata_i (obi_rdata_i),
    .pop_i   (fifo_pop),
    .rdata_o (fifo_rdata),
    .empty_o (fifo_empty),
    .free_o  (fifo_free)
  );

  memcopy_writer i_memcopy_writer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start),
    .dst_ptr_i    (dst_ptr),
    .size_i       (size),
    .fifo_empty_i (fifo_empty),
    .fifo_data_i  (fifo_rdata),
    .fifo_pop_o   (fifo_pop),
    .req_o        (wr_req),
    .addr_o       (wr_addr),
    .wdata_o      (wr_wdata),
    .gnt_i        (wr_gnt),
    .rvalid_i     (wr_rvalid),
    .done_o       (done)
  );

  memcopy_bus_arbiter i_memcopy_bus_arbiter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .rd_gnt_o     (rd_gnt),
    .rd_rvalid_o  (rd_rvalid),
    .wr_req_i     (wr_req),
    .wr_addr_i    (wr_addr),
    .wr_wdata_i   (wr_wdata),
    .wr_gnt_o     (wr_gnt),
    .wr_rvalid_o  (wr_rvalid),
    .obi_req_o    (obi_req_o),
    .obi_we_o     (obi_we_o),
    .obi_be_o     (obi_be_o),
    .obi_addr_o   (obi_addr_o),
    .obi_wdata_o  (obi_wdata_o),
    .obi_gnt_i    (obi_gnt_i),
    .obi_rvalid_i (obi_rvalid_i)
  );

endmodule

`default_nettype wire

//--- memcopy_periph_assertions.sv
//////////////////////////////////////////////////////////////////////
// Bus and interrupt rules of the memory-copy peripheral
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memcopy_periph_assertions (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               req_i,
  input logic               we_i,
  input memcopy_pkg::addr_t addr_i,
  input memcopy_pkg::data_t wdata_i,
  input logic               gnt_i,
  input logic               rvalid_i,
  input logic               intr_i
);

  int outstanding_q;
  int fail_count;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 0;
    end else if (req_i && gnt_i && !rvalid_i) begin
      outstanding_q <= outstanding_q + 1;
    end else if (!(req_i && gnt_i) && rvalid_i) begin
      outstanding_q <= outstanding_q - 1;
    end
  end

  // Sampled mid-cycle where all bus signals are settled
  a_req_stable: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    (req_i && !gnt_i) |=>
      (req_i && $stable(addr_i) && $stable(we_i) && (!we_i || $stable(wdata_i))))
    else begin
      fail_count++;
      $error("bus request changed before its grant");
    end

  a_intr_pulse: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    intr_i |=> !intr_i)
    else begin
      fail_count++;
      $error("interrupt high for two cycles in a row");
    end

  a_rvalid_owned: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> (outstanding_q != 0))
    else begin
      fail_count++;
      $error("response with no transaction outstanding");
    end

endmodule

`default_nettype wire

//--- memcopy_pkg.sv
//////////////////////////////////////////////////////////////////////
// Memory-copy peripheral shared types, register map, buffer sizes
// and engine state encodings
//////////////////////////////////////////////////////////////////////

`default_nettype none

package memcopy_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [15:0] word_cnt_t;
  typedef logic [3:0]  reg_addr_t;

  // Register map, byte offsets
  localparam reg_addr_t REG_SRC_PTR = 4'h0;
  localparam reg_addr_t REG_DST_PTR = 4'h4;
  localparam reg_addr_t REG_SIZE    = 4'h8;
  localparam reg_addr_t REG_STATUS  = 4'hc;

  // Depths must stay powers of two, pointers wrap naturally
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int ARB_DEPTH  = 4;
  localparam int ARB_PTR_W  = $clog2(ARB_DEPTH);

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;
  typedef logic [ARB_PTR_W-1:0]  arb_ptr_t;
  typedef logic [ARB_PTR_W:0]    arb_cnt_t;

  typedef enum logic {
    RD_IDLE,
    RD_RUN
  } reader_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_RUN,
    WR_DRAIN
  } writer_state_t;

endpackage

`default_nettype wire

//--- memcopy_reader.sv
//////////////////////////////////////////////////////////////////////
// Memory-copy read engine, issues word reads while FIFO credit lasts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memcopy_reader (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  memcopy_pkg::addr_t     src_ptr_i,
  input  memcopy_pkg::word_cnt_t size_i,
  output logic                   req_o,
  output memcopy_pkg::addr_t     addr_o,
  input  logic                   gnt_i,
  input  logic                   rvalid_i,
  input  memcopy_pkg::fifo_cnt_t fifo_free_i
);

  memcopy_pkg::reader_state_t state_q;
  memcopy_pkg::addr_t         addr_q;
  memcopy_pkg::word_cnt_t     left_q;
  memcopy_pkg::fifo_cnt_t     inflight_q;

  // Free space less reads in flight must stay positive
  assign req_o  = (state_q == memcopy_pkg::RD_RUN) && (fifo_free_i > inflight_q);
  assign addr_o = addr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= memcopy_pkg::RD_IDLE;
      inflight_q <= '0;
    end else begin
      case ({gnt_i, rvalid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: ;
      endcase
      case (state_q)
        memcopy_pkg::RD_IDLE: begin
          if (start_i) begin
            state_q <= memcopy_pkg::RD_RUN;
          end
        end
        memcopy_pkg::RD_RUN: begin
          if (gnt_i && (left_q == 16'd1)) begin
            state_q <= memcopy_pkg::RD_IDLE;
          end
        end
        default: state_q <= memcopy_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= src_ptr_i;
      left_q <= size_i;
    end else if (gnt_i) begin
      addr_q <= addr_q + 32'd4;
      left_q <= left_q - 16'd1;
    end
  end

endmodule

`default_nettype wire

//--- memcopy_regs.sv
//////////////////////////////////////////////////////////////////////
// Memory-copy register front end: pointers, word count, busy flag,
// start pulse and completion interrupt
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memcopy_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  memcopy_pkg::reg_addr_t reg_addr_i,
  input  memcopy_pkg::data_t     reg_wdata_i,
  output logic                   reg_ready_o,
  output memcopy_pkg::data_t     reg_rdata_o,
  output logic                   reg_error_o,
  output logic                   start_o,
  output memcopy_pkg::addr_t     src_ptr_o,
  output memcopy_pkg::addr_t     dst_ptr_o,
  output memcopy_pkg::word_cnt_t size_o,
  input  logic                   done_i,
  output logic                   intr_o
);

  memcopy_pkg::addr_t     src_ptr_q;
  memcopy_pkg::addr_t     dst_ptr_q;
  memcopy_pkg::word_cnt_t size_q;
  memcopy_pkg::word_cnt_t wdata_size;
  logic                   busy_q;
  logic                   start_q;
  logic                   intr_q;
  logic                   addr_hit;
  logic                   wr_ok;

  assign wdata_size = memcopy_pkg::word_cnt_t'(reg_wdata_i);

  // Single-cycle access, always ready
  assign reg_ready_o = reg_valid_i;

  always_comb begin
    addr_hit    = 1'b1;
    reg_rdata_o = '0;
    case (reg_addr_i)
      memcopy_pkg::REG_SRC_PTR: reg_rdata_o = src_ptr_q;
      memcopy_pkg::REG_DST_PTR: reg_rdata_o = dst_ptr_q;
      memcopy_pkg::REG_SIZE:    reg_rdata_o = memcopy_pkg::data_t'(size_q);
      memcopy_pkg::REG_STATUS:  reg_rdata_o = memcopy_pkg::data_t'(busy_q);
      default:                  addr_hit = 1'b0;
    endcase
  end

  // Bad offset, status write, or resize during a copy
  assign reg_error_o = reg_valid_i &&
                       (!addr_hit ||
                        (reg_write_i && (reg_addr_i == memcopy_pkg::REG_STATUS)) ||
                        (reg_write_i && (reg_addr_i == memcopy_pkg::REG_SIZE) && busy_q));

  assign wr_ok = reg_valid_i && reg_write_i && !reg_error_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_ptr_q <= '0;
      dst_ptr_q <= '0;
      size_q    <= '0;
      busy_q    <= 1'b0;
      start_q   <= 1'b0;
      intr_q    <= 1'b0;
    end else begin
      start_q <= 1'b0;
      intr_q  <= done_i;
      if (done_i) begin
        busy_q <= 1'b0;
      end
      if (wr_ok) begin
        case (reg_addr_i)
          memcopy_pkg::REG_SRC_PTR: src_ptr_q <= reg_wdata_i;
          memcopy_pkg::REG_DST_PTR: dst_ptr_q <= reg_wdata_i;
          memcopy_pkg::REG_SIZE: begin
            size_q <= wdata_size;
            // Zero length is stored but never launched
            if (wdata_size != '0) begin
              start_q <= 1'b1;
              busy_q  <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign start_o   = start_q;
  assign src_ptr_o = src_ptr_q;
  assign dst_ptr_o = dst_ptr_q;
  assign size_o    = size_q;
  assign intr_o    = intr_q;

endmodule

`default_nettype wire

//--- memcopy_trace.txt
# memcopy_periph trace, all fields hex
# P addr first count | W offset wdata err | R offset rdata err | C src dst words | Z
R c 00000000 0
W 0 00000100 0
R 0 00000100 0
W 4 00000300 0
R 4 00000300 0
R 2 00000000 1
W 7 deadbeef 1
W c 00000001 1
R c 00000000 0
R 0 00000100 0
Z
R 8 00000000 0
P 00000100 a5000000 8
P 00000400 3c000100 24
C 00000100 00000300 8
C 00000400 00000800 24
C 00000300 00000c00 3
R 8 00000003 0
R c 00000000 0

//--- memcopy_writer.sv
//////////////////////////////////////////////////////////////////////
// Memory-copy write engine, drains the FIFO and signals completion
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memcopy_writer (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  memcopy_pkg::addr_t     dst_ptr_i,
  input  memcopy_pkg::word_cnt_t size_i,
  input  logic                   fifo_empty_i,
  input  memcopy_pkg::data_t     fifo_data_i,
  output logic                   fifo_pop_o,
  output logic                   req_o,
  output memcopy_pkg::addr_t     addr_o,
  output memcopy_pkg::data_t     wdata_o,
  input  logic                   gnt_i,
  input  logic                   rvalid_i,
  output logic                   done_o
);

  memcopy_pkg::writer_state_t state_q;
  memcopy_pkg::addr_t         addr_q;
  memcopy_pkg::word_cnt_t     issue_left_q;
  memcopy_pkg::word_cnt_t     resp_left_q;
  logic                       done_q;

  // Head word stays put until the grant pops it
  assign req_o      = (state_q == memcopy_pkg::WR_RUN) && !fifo_empty_i;
  assign fifo_pop_o = req_o && gnt_i;
  assign addr_o     = addr_q;
  assign wdata_o    = fifo_data_i;
  assign done_o     = done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= memcopy_pkg::WR_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        memcopy_pkg::WR_IDLE: begin
          if (start_i) begin
            state_q <= memcopy_pkg::WR_RUN;
          end
        end
        memcopy_pkg::WR_RUN: begin
          if (gnt_i && (issue_left_q == 16'd1)) begin
            state_q <= memcopy_pkg::WR_DRAIN;
          end
        end
        memcopy_pkg::WR_DRAIN: begin
          if (rvalid_i && (resp_left_q == 16'd1)) begin
            done_q  <= 1'b1;
            state_q <= memcopy_pkg::WR_IDLE;
          end
        end
        default: state_q <= memcopy_pkg::WR_IDLE;
      endcase
    end
  end

  // Responses can already arrive while writes are still issued
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q       <= dst_ptr_i;
      issue_left_q <= size_i;
      resp_left_q  <= size_i;
    end else begin
      if (gnt_i) begin
        addr_q       <= addr_q + 32'd4;
        issue_left_q <= issue_left_q - 16'd1;
      end
      if (rvalid_i) begin
        resp_left_q <= resp_left_q - 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- slow_memory_model.sv
//////////////////////////////////////////////////////////////////////
// Slow word memory for the bus master port, random grant and
// response delays, in-order responses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module slow_memory_model (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [3:0]          be_i,
  input  logic [31:0]         addr_i,
  input  logic [31:0]         wdata_i,
  output logic                gnt_o,
  output logic [31:0]         rdata_o,
  output logic                rvalid_o
);

  localparam int WORDS = 1024;

  logic [31:0] mem_q [WORDS];
  int          gnt_wait_q;
  int          cycle_q;
  int          last_due_q;
  int          due_q [$];
  logic [31:0] data_q [$];

  assign gnt_o = req_i && (gnt_wait_q == 0);

  initial begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    for (int i = 0; i < WORDS; i++) begin
      mem_q[i] = 32'hc0de_0000 ^ (32'(i) << 2);
    end
  end

  function automatic logic [31:0] peek(input logic [31:0] addr);
    return mem_q[addr[11:2]];
  endfunction

  function automatic void poke(input logic [31:0] addr, input logic [31:0] data);
    mem_q[addr[11:2]] = data;
  endfunction

  always @(posedge clk_i) begin
    int due;
    if (!rst_n_i) begin
      gnt_wait_q <= 0;
      cycle_q    <= 0;
      last_due_q <= 0;
      rvalid_o   <= 1'b0;
      rdata_o    <= '0;
      due_q.delete();
      data_q.delete();
    end else begin
      cycle_q <= cycle_q + 1;
      if (req_i && gnt_o) begin
        // Keep responses in grant order
        due = cycle_q + int'($urandom_range(3, 1));
        if (due <= last_due_q) begin
          due = last_due_q + 1;
        end
        last_due_q <= due;
        due_q.push_back(due);
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
              mem_q[addr_i[11:2]][8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
          data_q.push_back('0);
        end else begin
          data_q.push_back(mem_q[addr_i[11:2]]);
        end
        gnt_wait_q <= int'($urandom_range(3, 0));
      end else if (req_i && (gnt_wait_q != 0)) begin
        gnt_wait_q <= gnt_wait_q - 1;
      end
      rvalid_o <= 1'b0;
      if ((due_q.size() != 0) && (due_q[0] == cycle_q + 1)) begin
        rvalid_o <= 1'b1;
        rdata_o  <= data_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_memcopy_periph.sv
//////////////////////////////////////////////////////////////////////
// Memory-copy peripheral testbench, trace driven register accesses
// and copies against a slow memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_memcopy_periph;

  logic                   clk;
  logic                   rst_n;
  logic                   reg_valid;
  logic                   reg_write;
  memcopy_pkg::reg_addr_t reg_addr;
  memcopy_pkg::data_t     reg_wdata;
  logic                   reg_ready;
  memcopy_pkg::data_t     reg_rdata;
  logic                   reg_error;
  logic                   obi_req;
  logic                   obi_we;
  memcopy_pkg::be_t       obi_be;
  memcopy_pkg::addr_t     obi_addr;
  memcopy_pkg::data_t     obi_wdata;
  logic                   obi_gnt;
  memcopy_pkg::data_t     obi_rdata;
  logic                   obi_rvalid;
  logic                   intr;

  logic [7:0]  op_q [$];
  logic [31:0] arg_a_q [$];
  logic [31:0] arg_b_q [$];
  logic [31:0] arg_c_q [$];
  logic [31:0] ref_mem [logic [31:0]];
  int          cycle_cnt;
  int          cycle_limit;
  int          intr_count;

  memcopy_periph i_memcopy_periph (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .reg_valid_i    (reg_valid),
    .reg_write_i    (reg_write),
    .reg_addr_i     (reg_addr),
    .reg_wdata_i    (reg_wdata),
    .reg_ready_o    (reg_ready),
    .reg_rdata_o    (reg_rdata),
    .reg_error_o    (reg_error),
    .obi_req_o      (obi_req),
    .obi_we_o       (obi_we),
    .obi_be_o       (obi_be),
    .obi_addr_o     (obi_addr),
    .obi_wdata_o    (obi_wdata),
    .obi_gnt_i      (obi_gnt),
    .obi_rdata_i    (obi_rdata),
    .obi_rvalid_i   (obi_rvalid),
    .memcopy_intr_o (intr)
  );

  slow_memory_model i_mem (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .req_i    (obi_req),
    .we_i     (obi_we),
    .be_i     (obi_be),
    .addr_i   (obi_addr),
    .wdata_i  (obi_wdata),
    .gnt_o    (obi_gnt),
    .rdata_o  (obi_rdata),
    .rvalid_o (obi_rvalid)
  );

  bind memcopy_periph memcopy_periph_assertions i_assertions (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (obi_req_o),
    .we_i     (obi_we_o),
    .addr_i   (obi_addr_o),
    .wdata_i  (obi_wdata_o),
    .gnt_i    (obi_gnt_i),
    .rvalid_i (obi_rvalid_i),
    .intr_i   (memcopy_intr_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run went past %0d cycles", cycle_limit);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  // Interrupt is a flop output, settled at the falling edge
  always @(negedge clk) begin
    if (intr) begin
      intr_count <= intr_count + 1;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_with(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "run aborted");
  endtask

  task automatic read_trace();
    int          fd;
    int          n;
    int          total_words;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    total_words = 0;
    fd = $fopen("memcopy_trace.txt", "r");
    if (fd == 0) begin
      stop_with("cannot open the trace file memcopy_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if ((line.len() < 2) || (line.getc(0) == "#")) begin
        continue;
      end
      a = '0;
      b = '0;
      c = '0;
      n = $sscanf(line, "%c %h %h %h", op, a, b, c);
      if ((op != "Z") && (n != 4)) begin
        stop_with($sformatf("malformed trace line: %s", line));
      end
      op_q.push_back(op);
      arg_a_q.push_back(a);
      arg_b_q.push_back(b);
      arg_c_q.push_back(c);
      if (op == "C") begin
        total_words += int'(c);
      end
    end
    $fclose(fd);
    cycle_limit = 40 * total_words + 200;
  endtask

  // Called just after a rising edge, returns just after a rising edge
  task automatic reg_access(input logic write, input memcopy_pkg::reg_addr_t addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rdata,
                            input logic exp_err);
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    @(negedge clk);
    check("reg_ready_o", 32'(reg_ready), 32'd1);
    check("reg_error_o", 32'(reg_error), 32'(exp_err));
    if (!write) begin
      check("reg_rdata_o", reg_rdata, exp_rdata);
    end
    @(posedge clk);
    #1;
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  // Word k of the block is first + k
  task automatic preload(input logic [31:0] addr, input logic [31:0] first,
                         input logic [31:0] count);
    logic [31:0] word_addr;
    for (int k = 0; k < int'(count); k++) begin
      word_addr = addr + (32'(k) << 2);
      ref_mem[word_addr] = first + 32'(k);
      i_mem.poke(word_addr, first + 32'(k));
    end
  endtask

  task automatic run_copy(input logic [31:0] src, input logic [31:0] dst,
                          input logic [31:0] words);
    logic [31:0] expected [$];
    logic [31:0] word_addr;
    int          pulses_before;
    for (int k = 0; k < int'(words); k++) begin
      word_addr = src + (32'(k) << 2);
      if (!ref_mem.exists(word_addr)) begin
        stop_with($sformatf("copy source word at %h was never preloaded", word_addr));
      end
      expected.push_back(ref_mem[word_addr]);
    end
    pulses_before = intr_count;
    reg_access(1'b1, memcopy_pkg::REG_SRC_PTR, src, '0, 1'b0);
    reg_access(1'b1, memcopy_pkg::REG_DST_PTR, dst, '0, 1'b0);
    reg_access(1'b1, memcopy_pkg::REG_SIZE, words, '0, 1'b0);
    reg_access(1'b0, memcopy_pkg::REG_STATUS, '0, 32'd1, 1'b0);
    // Resize attempt while the copy runs
    reg_access(1'b1, memcopy_pkg::REG_SIZE, 32'd1, '0, 1'b1);
    do begin
      @(negedge clk);
    end while (!intr);
    repeat (4) @(posedge clk);
    #1;
    check("memcopy_intr_o pulse count", 32'(intr_count - pulses_before), 32'd1);
    reg_access(1'b0, memcopy_pkg::REG_STATUS, '0, 32'd0, 1'b0);
    reg_access(1'b0, memcopy_pkg::REG_SIZE, '0, words, 1'b0);
    for (int k = 0; k < int'(words); k++) begin
      word_addr = dst + (32'(k) << 2);
      check($sformatf("memory word %h", word_addr), i_mem.peek(word_addr), expected[k]);
      ref_mem[word_addr] = expected[k];
    end
  endtask

  task automatic zero_size();
    int pulses_before;
    pulses_before = intr_count;
    reg_access(1'b1, memcopy_pkg::REG_SIZE, 32'd0, '0, 1'b0);
    repeat (50) @(negedge clk);
    @(posedge clk);
    #1;
    check("memcopy_intr_o pulse count", 32'(intr_count - pulses_before), 32'd0);
    reg_access(1'b0, memcopy_pkg::REG_STATUS, '0, 32'd0, 1'b0);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    void'($urandom(32'hf4ee_0f91));
    read_trace();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (op_q[k]) begin
      case (op_q[k])
        "P": preload(arg_a_q[k], arg_b_q[k], arg_c_q[k]);
        "W": reg_access(1'b1, memcopy_pkg::reg_addr_t'(arg_a_q[k]), arg_b_q[k], '0,
                        arg_c_q[k][0]);
        "R": reg_access(1'b0, memcopy_pkg::reg_addr_t'(arg_a_q[k]), '0, arg_b_q[k],
                        arg_c_q[k][0]);
        "C": run_copy(arg_a_q[k], arg_b_q[k], arg_c_q[k]);
        "Z": zero_size();
        default: stop_with($sformatf("unknown trace operation %c", op_q[k]));
      endcase
    end
    repeat (2) @(posedge clk);
    if (i_memcopy_periph.i_assertions.fail_count != 0) begin
      $display("%0d bus or interrupt rule violations",
               i_memcopy_periph.i_assertions.fail_count);
      $display("Finished with errors");
      $fatal(1, "assertion failures");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire
